/* design/rd_dp_macros.svh */
/* Constants for the full-rate read datapath
   Group count, data widths, FIFO depth, latency range and OCT window taps */

`ifndef RD_DP_MACROS_SVH
`define RD_DP_MACROS_SVH

// Two DQS groups of eight DQ bits each
`define RD_DQS_GROUPS     2
`define RD_DQ_PER_GROUP   8
// Full rate, so one AFI cycle carries both DDIO edges
`define RD_TIMESLOTS      2

// Read data FIFO, one per DQS group
`define RD_FIFO_DEPTH     8
`define RD_FIFO_AW        3

// The request shifter covers every latency a 4-bit counter can name
`define RD_MAX_LATENCY    16
`define RD_LAT_W          4

// OCT window taps follow the memory read latency in AFI cycles
`define RD_MEM_T_RL       8
`define RD_OCT_ON_DELAY   ((`RD_MEM_T_RL > 4) ? ((`RD_MEM_T_RL - 4) / 2) : 0)
`define RD_OCT_OFF_DELAY  ((`RD_MEM_T_RL + 6) / 2)

`endif

/* design/rd_dp_pkg.sv */
/* Types shared across the read datapath
   Data word layouts for DDIO and AFI buses, and the sequencer configuration */

`include "rd_dp_macros.svh"

package rd_dp_pkg;

	// One bit per DQS group, used for clocks, resets and OCT controls
	typedef logic [`RD_DQS_GROUPS-1:0] grp_mask_t;

	// Latency counter as programmed by the sequencer
	typedef logic [`RD_LAT_W-1:0] rd_lat_t;

	// One group's data for one AFI cycle, indexed by timeslot
	typedef logic [`RD_TIMESLOTS-1:0][`RD_DQ_PER_GROUP-1:0] dq_group_word_t;

	// DDIO input bus is group-major
	typedef dq_group_word_t [`RD_DQS_GROUPS-1:0] ddio_dq_t;

	// AFI output bus is timeslot-major, each timeslot holds every group
	typedef logic [`RD_TIMESLOTS-1:0][`RD_DQS_GROUPS-1:0][`RD_DQ_PER_GROUP-1:0] afi_rdata_t;

	// Sequencer controls for the read path
	typedef struct packed
	{
		grp_mask_t fifo_reset;
		rd_lat_t   latency;
	} rd_seq_cfg_t;

endpackage

/* design/read_cfg_regs.sv */
/* Sequencer configuration registers beside the read datapath
   Holds read latency and FIFO reset requests, and makes the write-side resets */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module read_cfg_regs
	import rd_dp_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	input  rd_seq_cfg_t seq_cfg_i,
	output rd_seq_cfg_t cfg_o,
	output grp_mask_t   wr_reset_n_o
);

	// Registered copy of the sequencer controls
	rd_seq_cfg_t cfg_q;

	// Dedicated active-low reset for each group's capture-clock pointer
	grp_mask_t wr_reset_n_q;

	// ****************************************
	// Configuration capture
	// ****************************************

	// The write pointers live on the capture clock, so their reset must
	// come straight from a flop and never from sequencer logic.
	// It is held low through system reset and for every cycle in which
	// the registered fifo_reset is high
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			cfg_q        <= '0;
			wr_reset_n_q <= '0;
		end
		else
		begin
			cfg_q        <= seq_cfg_i;
			wr_reset_n_q <= ~seq_cfg_i.fifo_reset;
		end
	end

	assign cfg_o        = cfg_q;
	assign wr_reset_n_o = wr_reset_n_q;

endmodule

/* design/read_latency_shifter.sv */
/* Read request latency shifter
   Taps delayed request streams to make read enable and the AFI read valid */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module read_latency_shifter
	import rd_dp_pkg::*;
(
	input  logic    pll_afi_clk,
	input  logic    reset_n_afi_clk,
	input  logic    rdata_en_i,
	input  logic    rdata_en_full_i,
	input  rd_lat_t latency_i,
	output logic    read_enable_o,
	output logic    afi_rdata_valid_o
);

	// Bit k holds the request sampled k+1 edges ago
	logic [`RD_MAX_LATENCY-1:0] en_shift_q;
	logic [`RD_MAX_LATENCY-1:0] en_full_shift_q;

	// Request stream delayed by the programmed latency
	logic valid_tap;

	// ****************************************
	// Request history
	// ****************************************

	// Both streams shift every cycle, so back-to-back requests each
	// keep their own slot and up to L of them are in flight at once
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_shift_q      <= '0;
			en_full_shift_q <= '0;
		end
		else
		begin
			en_shift_q      <= {en_shift_q[`RD_MAX_LATENCY-2:0], rdata_en_i};
			en_full_shift_q <= {en_full_shift_q[`RD_MAX_LATENCY-2:0], rdata_en_full_i};
		end
	end

	// ****************************************
	// Latency taps
	// ****************************************

	// Read enable fires L cycles after the full request.
	// The FIFO loads its data register on that same cycle's closing edge
	assign read_enable_o = en_full_shift_q[latency_i];
	assign valid_tap     = en_shift_q[latency_i];

	// Valid is registered so it rises with the FIFO output data
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			afi_rdata_valid_o <= 1'b0;
		else
			afi_rdata_valid_o <= valid_tap;
	end

endmodule

/* design/read_fifo_group.sv */
/* Read data FIFO for one DQS group
   Written on the group's capture clock and read on the AFI clock */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module read_fifo_group
	import rd_dp_pkg::*;
(
	input  logic           pll_afi_clk,
	input  logic           read_capture_clk_i,
	input  logic           wr_reset_n_i,
	input  logic           fifo_reset_i,
	input  logic           read_enable_i,
	input  dq_group_word_t wr_data_i,
	output dq_group_word_t rd_data_o
);

	// Flop-based storage, one captured word per slot
	dq_group_word_t mem [`RD_FIFO_DEPTH];

	logic [`RD_FIFO_AW-1:0] wr_ptr;
	logic [`RD_FIFO_AW-1:0] rd_ptr;

	// Next pointer value with wrap at the last slot
	function automatic logic [`RD_FIFO_AW-1:0] ptr_next(input logic [`RD_FIFO_AW-1:0] ptr);
		if (int'(ptr) == `RD_FIFO_DEPTH - 1)
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// ****************************************
	// Write side on the capture clock
	// ****************************************

	// The reset comes from an AFI-clock flop. The capture clock trails the
	// AFI clock by a fixed phase, so release never lands near a capture edge
	always_ff @(posedge read_capture_clk_i or negedge wr_reset_n_i)
	begin
		if (!wr_reset_n_i)
			wr_ptr <= '0;
		else
			wr_ptr <= ptr_next(wr_ptr);
	end

	// Every capture edge writes, even while the pointer is held in reset.
	// Slot 0 is simply overwritten until the pointer is released
	always_ff @(posedge read_capture_clk_i)
	begin
		mem[wr_ptr] <= wr_data_i;
	end

	// ****************************************
	// Read side on the AFI clock
	// ****************************************

	// The write-side reset is an AFI-clock flop that is low through system
	// reset, so it also clears the read pointer synchronously
	always_ff @(posedge pll_afi_clk)
	begin
		if (fifo_reset_i || !wr_reset_n_i)
			rd_ptr <= '0;
		else if (read_enable_i)
			rd_ptr <= ptr_next(rd_ptr);
	end

	// Output word updates only on a read and holds otherwise
	always_ff @(posedge pll_afi_clk)
	begin
		if (read_enable_i)
			rd_data_o <= mem[rd_ptr];
	end

endmodule

/* design/oct_ctrl.sv */
/* On-die termination window control
   Forces OCT off around read data using a short history of read requests */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module oct_ctrl
	import rd_dp_pkg::*;
(
	input  logic      pll_afi_clk,
	input  logic      reset_n_afi_clk,
	input  logic      rdata_en_full_i,
	output grp_mask_t force_oct_off_o
);

	// Past full requests, bit k is the request from k+1 cycles ago
	logic [`RD_OCT_OFF_DELAY-1:0] en_hist_q;

	// Current request at tap 0 followed by the history
	logic [`RD_OCT_OFF_DELAY:0] en_taps;

	// High when any request sits inside the window
	logic read_in_window;

	assign en_taps        = {en_hist_q, rdata_en_full_i};
	assign read_in_window = |en_taps[`RD_OCT_OFF_DELAY:`RD_OCT_ON_DELAY];

	// ****************************************
	// History and registered window
	// ****************************************

	// Termination stays enabled while data is on the bus and is forced
	// off for all other cycles. Every group sees the same window
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist_q       <= '0;
			force_oct_off_o <= '0;
		end
		else
		begin
			en_hist_q       <= en_taps[`RD_OCT_OFF_DELAY-1:0];
			force_oct_off_o <= {`RD_DQS_GROUPS{~read_in_window}};
		end
	end

endmodule

/* design/read_datapath_top.sv */
/* Full-rate DDR3 read datapath top level
   Config registers, latency shifter, OCT window and one read FIFO per group */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module read_datapath_top
	import rd_dp_pkg::*;
(
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	input  grp_mask_t   read_capture_clk_i,
	input  ddio_dq_t    ddio_phy_dq_i,
	input  logic        afi_rdata_en_i,
	input  logic        afi_rdata_en_full_i,
	input  rd_seq_cfg_t seq_cfg_i,
	output afi_rdata_t  afi_rdata_o,
	output logic        afi_rdata_valid_o,
	output grp_mask_t   force_oct_off_o
);

	// Registered sequencer controls
	rd_seq_cfg_t cfg_q;
	grp_mask_t   wr_reset_n;

	// One read enable serves all groups since they share a latency
	logic read_enable;

	// FIFO outputs, still group-major
	ddio_dq_t fifo_rdata;

	read_cfg_regs cfg_regs0 (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.seq_cfg_i       (seq_cfg_i),
		.cfg_o           (cfg_q),
		.wr_reset_n_o    (wr_reset_n)
	);

	read_latency_shifter lat_shifter0 (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.rdata_en_i        (afi_rdata_en_i),
		.rdata_en_full_i   (afi_rdata_en_full_i),
		.latency_i         (cfg_q.latency),
		.read_enable_o     (read_enable),
		.afi_rdata_valid_o (afi_rdata_valid_o)
	);

	oct_ctrl oct_ctrl0 (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o (force_oct_off_o)
	);

	// ****************************************
	// Per-group FIFOs and AFI reordering
	// ****************************************

	for (genvar g = 0; g < `RD_DQS_GROUPS; g++)
	begin : g_grp
		read_fifo_group fifo0 (
			.pll_afi_clk        (pll_afi_clk),
			.read_capture_clk_i (read_capture_clk_i[g]),
			.wr_reset_n_i       (wr_reset_n[g]),
			.fifo_reset_i       (cfg_q.fifo_reset[g]),
			.read_enable_i      (read_enable),
			.wr_data_i          (ddio_phy_dq_i[g]),
			.rd_data_o          (fifo_rdata[g])
		);

		// Each timeslot of the AFI bus gathers that timeslot from every group
		for (genvar ts = 0; ts < `RD_TIMESLOTS; ts++)
		begin : g_ts
			assign afi_rdata_o[ts][g] = fifo_rdata[g][ts];
		end
	end

endmodule

/* verification/read_datapath_props.sv */
/* Bound checker for the read datapath top level
   Concurrent assertions on reset values, read valid latency and the OCT window */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module read_datapath_props
	import rd_dp_pkg::*;
(
	input logic        pll_afi_clk,
	input logic        reset_n_afi_clk,
	input logic        rdata_en_i,
	input logic        rdata_en_full_i,
	input rd_seq_cfg_t seq_cfg_i,
	input logic        rdata_valid_i,
	input grp_mask_t   force_oct_off_i
);

	// Bit k holds the request sampled k+1 edges before the current one
	logic [`RD_MAX_LATENCY:0]   en_hist_q;
	logic [`RD_OCT_OFF_DELAY:0] en_full_hist_q;

	// Latency as the top level registers it and its copy from one cycle earlier
	rd_lat_t lat_q;
	rd_lat_t lat_d;

	// Set once the outputs come from logic that has left reset
	logic armed_q;

	int unsigned fail_cnt = 0;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist_q      <= '0;
			en_full_hist_q <= '0;
			lat_q          <= '0;
			lat_d          <= '0;
			armed_q        <= 1'b0;
		end
		else
		begin
			en_hist_q      <= {en_hist_q[`RD_MAX_LATENCY-1:0], rdata_en_i};
			en_full_hist_q <= {en_full_hist_q[`RD_OCT_OFF_DELAY-1:0], rdata_en_full_i};
			lat_q          <= seq_cfg_i.latency;
			lat_d          <= lat_q;
			armed_q        <= 1'b1;
		end
	end

	// ****************************************
	// Checks
	// ****************************************

	// Outputs sit at their reset values while reset is held
	reset_values: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> (!rdata_valid_i && force_oct_off_i == '0))
	else
	begin
		$error("read valid or force OCT off is not cleared during reset");
		fail_cnt++;
	end

	// A request shows up as valid L+2 sampling edges later
	valid_latency: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		armed_q |-> (rdata_valid_i == en_hist_q[int'(lat_d) + 1]))
	else
	begin
		$error("read valid does not follow the request by the programmed latency");
		fail_cnt++;
	end

	// Termination is kept on only while a request sits in taps 2 to 7
	oct_window: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		armed_q |-> (force_oct_off_i ==
		{`RD_DQS_GROUPS{~|en_full_hist_q[`RD_OCT_OFF_DELAY:`RD_OCT_ON_DELAY]}}))
	else
	begin
		$error("force OCT off does not match the read request window");
		fail_cnt++;
	end

endmodule

bind read_datapath_top read_datapath_props props0 (
	.pll_afi_clk     (pll_afi_clk),
	.reset_n_afi_clk (reset_n_afi_clk),
	.rdata_en_i      (afi_rdata_en_i),
	.rdata_en_full_i (afi_rdata_en_full_i),
	.seq_cfg_i       (seq_cfg_i),
	.rdata_valid_i   (afi_rdata_valid_o),
	.force_oct_off_i (force_oct_off_o)
);

/* verification/read_datapath_tb.sv */
/* Testbench for the full-rate read datapath
   Clocks, reset, random requests, FIFO shadow model, data checks and timeout */

`timescale 1ns/1ps

`include "rd_dp_macros.svh"

module read_datapath_tb
	import rd_dp_pkg::*;
();

	// Phase lengths in AFI cycles, the run limit follows from their sum
	localparam int RESET_CYCLES   = 5;
	localparam int FILL_CYCLES    = 20;
	localparam int LAT3_CYCLES    = 300;
	localparam int LAT9_CYCLES    = 250;
	localparam int RESTART_CYCLES = 100;
	localparam int GAP_CYCLES     = 30;
	localparam int TEST_CYCLES    = RESET_CYCLES + FILL_CYCLES + LAT3_CYCLES + LAT9_CYCLES
		+ RESTART_CYCLES + 4 * GAP_CYCLES + 12;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	logic        pll_afi_clk;
	logic        cap_clk;
	logic        reset_n_afi_clk;
	ddio_dq_t    ddio_dq = '0;
	logic        rdata_en = 1'b0;
	logic        rdata_en_full = 1'b0;
	rd_seq_cfg_t seq_cfg;
	afi_rdata_t  afi_rdata;
	logic        rdata_valid;
	grp_mask_t   force_oct_off;

	logic [31:0] rnd_state = 32'd26;
	logic        req_on = 1'b0;
	string       test_name = "reset";
	int          cycle_count;
	int          data_checks = 0;
	int          data_errors = 0;

	// Shadow of each group's FIFO slots and the expected read side
	dq_group_word_t             shadow [`RD_DQS_GROUPS][`RD_FIFO_DEPTH];
	dq_group_word_t             exp_word [`RD_DQS_GROUPS];
	int                         wr_count [`RD_DQS_GROUPS];
	int                         rd_count [`RD_DQS_GROUPS];
	logic [`RD_MAX_LATENCY-1:0] req_hist;
	rd_lat_t                    lat_m;
	grp_mask_t                  wr_rst_n_m;
	logic                       exp_valid;

	read_datapath_top dut0 (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.read_capture_clk_i  ({`RD_DQS_GROUPS{cap_clk}}),
		.ddio_phy_dq_i       (ddio_dq),
		.afi_rdata_en_i      (rdata_en),
		.afi_rdata_en_full_i (rdata_en_full),
		.seq_cfg_i           (seq_cfg),
		.afi_rdata_o         (afi_rdata),
		.afi_rdata_valid_o   (rdata_valid),
		.force_oct_off_o     (force_oct_off)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Holds requests on or off for a number of AFI cycles
	task automatic run_phase(input int cycles, input logic requests);
		req_on <= requests;
		repeat (cycles) @(posedge pll_afi_clk);
	endtask

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #50 pll_afi_clk = ~pll_afi_clk;
	end

	// Capture clock trails the AFI clock by a quarter period
	initial
	begin
		cap_clk = 1'b0;
		#25;
		forever #50 cap_clk = ~cap_clk;
	end

	// ****************************************
	// Stimulus
	// ****************************************

	// New DQ data every cycle, requests in random bursts of about 5 in 8
	always @(posedge pll_afi_clk)
	begin
		rnd_state     <= next_random(rnd_state);
		ddio_dq       <= rnd_state;
		rdata_en      <= req_on && (rnd_state[31:29] < 3'd5);
		rdata_en_full <= req_on && (rnd_state[31:29] < 3'd5);
	end

	// ****************************************
	// Shadow model
	// ****************************************

	// Each capture edge stores the current DQ word, slot 0 while the write side is held
	always @(posedge cap_clk)
	begin
		for (int g = 0; g < `RD_DQS_GROUPS; g++)
		begin
			if (!wr_rst_n_m[g])
				wr_count[g] = 0;
			shadow[g][wr_count[g]] = ddio_dq[g];
			if (wr_rst_n_m[g])
				wr_count[g] = (wr_count[g] + 1) % `RD_FIFO_DEPTH;
		end
	end

	// A full request read L+1 edges later loads the slot at the read count
	always @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			req_hist   <= '0;
			lat_m      <= '0;
			wr_rst_n_m <= '0;
			exp_valid  <= 1'b0;
			for (int g = 0; g < `RD_DQS_GROUPS; g++)
				rd_count[g] <= 0;
		end
		else
		begin
			req_hist   <= {req_hist[`RD_MAX_LATENCY-2:0], rdata_en_full};
			lat_m      <= seq_cfg.latency;
			wr_rst_n_m <= ~seq_cfg.fifo_reset;
			exp_valid  <= req_hist[lat_m];
			for (int g = 0; g < `RD_DQS_GROUPS; g++)
			begin
				if (req_hist[lat_m])
					exp_word[g] <= shadow[g][rd_count[g]];
				if (!wr_rst_n_m[g])
					rd_count[g] <= 0;
				else if (req_hist[lat_m])
					rd_count[g] <= (rd_count[g] + 1) % `RD_FIFO_DEPTH;
			end
		end
	end

	// Output bus is timeslot-major, compared away from the clock edge
	always @(negedge pll_afi_clk)
	begin
		if (exp_valid)
		begin
			for (int g = 0; g < `RD_DQS_GROUPS; g++)
			begin
				for (int ts = 0; ts < `RD_TIMESLOTS; ts++)
				begin
					data_checks++;
					assert (afi_rdata[ts][g] == exp_word[g][ts])
					else
					begin
						$display("error %s: group %0d timeslot %0d expected %02h actual %02h",
							test_name, g, ts, exp_word[g][ts], afi_rdata[ts][g]);
						data_errors++;
					end
				end
			end
		end
	end

	// ****************************************
	// Sequence and end of run
	// ****************************************

	initial
	begin
		reset_n_afi_clk = 1'b0;
		seq_cfg         = '0;
		seq_cfg.latency = 4'd3;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		test_name = "valid_lat3";
		run_phase(FILL_CYCLES, 1'b0);
		run_phase(LAT3_CYCLES, 1'b1);
		run_phase(GAP_CYCLES, 1'b0);
		// Latency moves only while nothing is in flight
		seq_cfg.latency <= 4'd9;
		test_name = "valid_lat9";
		run_phase(GAP_CYCLES, 1'b0);
		run_phase(LAT9_CYCLES, 1'b1);
		run_phase(GAP_CYCLES, 1'b0);
		test_name = "fifo_reset";
		seq_cfg.fifo_reset <= '1;
		run_phase(2, 1'b0);
		seq_cfg.fifo_reset <= '0;
		run_phase(10, 1'b0);
		run_phase(RESTART_CYCLES, 1'b1);
		run_phase(GAP_CYCLES, 1'b0);
		$display("data checks %0d, data errors %0d, assertion failures %0d",
			data_checks, data_errors, dut0.props0.fail_cnt);
		if (data_errors == 0 && dut0.props0.fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge pll_afi_clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* sim.f */
+incdir+design
design/rd_dp_pkg.sv
design/read_cfg_regs.sv
design/read_latency_shifter.sv
design/read_fifo_group.sv
design/oct_ctrl.sv
design/read_datapath_top.sv
verification/read_datapath_props.sv
verification/read_datapath_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := read_datapath_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
